//--- verilog/dlx_params.svh
`ifndef DLX_PARAMS_SVH
`define DLX_PARAMS_SVH

//////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////
`define DLX_XLEN      32
`define DLX_REG_AW    5
`define DLX_NREGS     32
`define DLX_OPW       6
`define DLX_FNW       6
`define DLX_IMMW      16

// first fetch after reset
`define DLX_RESET_PC  32'h0000_0000

//////////////////////////////////////////////////
// major opcodes, bits 31:26
//////////////////////////////////////////////////
`define DLX_OP_RTYPE  6'h00
`define DLX_OP_J      6'h02
`define DLX_OP_BEQZ   6'h04
`define DLX_OP_BNEZ   6'h05
`define DLX_OP_ADDI   6'h08
`define DLX_OP_ANDI   6'h0c
`define DLX_OP_ORI    6'h0d
`define DLX_OP_LW     6'h23
`define DLX_OP_SW     6'h2b

// r-type func field, bits 5:0
`define DLX_FN_ADD    6'h20
`define DLX_FN_SUB    6'h22
`define DLX_FN_AND    6'h24
`define DLX_FN_OR     6'h25
`define DLX_FN_XOR    6'h26
`define DLX_FN_SLT    6'h2a

`endif

//--- verilog/dlx_pkg.sv
`include "dlx_params.svh"

package dlx_pkg;

    //////////////////////////////////////////////////
    // instruction word, two views of one word
    //////////////////////////////////////////////////

    // register-register form
    typedef struct packed {
        logic [`DLX_OPW-1:0]    opcode;
        logic [`DLX_REG_AW-1:0] rs1;
        logic [`DLX_REG_AW-1:0] rs2;
        logic [`DLX_REG_AW-1:0] rd;
        // shift amount field, unused here
        logic [`DLX_XLEN-`DLX_OPW-3*`DLX_REG_AW-`DLX_FNW-1:0] spare;
        logic [`DLX_FNW-1:0]    func;
    } dlx_rtype_t;

    // immediate form; J takes its offset from rs1, rd and imm together
    typedef struct packed {
        logic [`DLX_OPW-1:0]    opcode;
        logic [`DLX_REG_AW-1:0] rs1;
        logic [`DLX_REG_AW-1:0] rd;
        logic [`DLX_IMMW-1:0]   imm;
    } dlx_itype_t;

    typedef union packed {
        dlx_rtype_t r;
        dlx_itype_t i;
    } dlx_instr_u;

    // alu function select
    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_xor    = 3'd4,
        alu_slt    = 3'd5,
        alu_pass_b = 3'd6
    } dlx_alu_op_e;

    //////////////////////////////////////////////////
    // stage-to-stage bundles
    //////////////////////////////////////////////////
    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic branch;
        // set for BEQZ, clear for BNEZ
        logic branch_zero;
        logic jump;
        logic use_imm;
    } dlx_ctrl_t;

    typedef struct packed {
        logic                   valid;
        dlx_ctrl_t              ctrl;
        dlx_alu_op_e            alu_op;
        logic [`DLX_XLEN-1:0]   pc_plus4;
        logic [`DLX_REG_AW-1:0] rs1;
        logic [`DLX_REG_AW-1:0] rs2;
        logic [`DLX_XLEN-1:0]   rs1_data;
        logic [`DLX_XLEN-1:0]   rs2_data;
        logic [`DLX_REG_AW-1:0] rd;
        logic [`DLX_XLEN-1:0]   imm;
    } dlx_id_ex_t;

    typedef struct packed {
        logic                   valid;
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        logic [`DLX_REG_AW-1:0] rd;
        logic [`DLX_REG_AW-1:0] rs2;
        logic [`DLX_XLEN-1:0]   alu_result;
        logic [`DLX_XLEN-1:0]   store_val;
    } dlx_ex_mem_t;

    typedef struct packed {
        logic                   valid;
        logic                   reg_write;
        logic [`DLX_REG_AW-1:0] rd;
        logic [`DLX_XLEN-1:0]   result;
    } dlx_mem_wb_t;

    // register file write port
    typedef struct packed {
        logic                   we;
        logic [`DLX_REG_AW-1:0] rd;
        logic [`DLX_XLEN-1:0]   data;
    } dlx_wb_t;

    typedef struct packed {
        logic                 take;
        logic [`DLX_XLEN-1:0] target;
    } dlx_redirect_t;

    typedef struct packed {
        logic [`DLX_XLEN-1:0] addr;
        logic [`DLX_XLEN-1:0] wdata;
        logic                 we;
        logic                 re;
    } dlx_dmem_req_t;

endpackage

//--- verilog/dlx_regfile.sv
`include "dlx_params.svh"

module dlx_regfile import dlx_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`DLX_REG_AW-1:0] rs1,
    input  logic [`DLX_REG_AW-1:0] rs2,
    input  dlx_wb_t                wb,
    output logic [`DLX_XLEN-1:0]   rs1_data,
    output logic [`DLX_XLEN-1:0]   rs2_data
);

    // r1..r31 only, r0 has no storage
    logic [`DLX_XLEN-1:0] regs [1:`DLX_NREGS-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '{default: '0};
        end else if (wb.we && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // r0 reads zero; same-cycle write is passed straight through
    function automatic logic [`DLX_XLEN-1:0] read_reg(input logic [`DLX_REG_AW-1:0] idx);
        logic [`DLX_XLEN-1:0] val;
        if (idx == '0) begin
            val = '0;
        end else if (wb.we && wb.rd == idx) begin
            val = wb.data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rs1_data = read_reg(rs1);
        rs2_data = read_reg(rs2);
    end

endmodule

//--- verilog/dlx_decode.sv
`include "dlx_params.svh"

module dlx_decode import dlx_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [`DLX_XLEN-1:0] pc_plus4,
    input  dlx_instr_u           instr,
    input  logic                 instr_valid,
    input  dlx_wb_t              wb,
    input  logic                 flush,
    output logic                 stall,
    output dlx_id_ex_t           id_ex
);

    dlx_ctrl_t              ctrl;
    dlx_alu_op_e            alu_op;
    logic [`DLX_REG_AW-1:0] src1;
    logic [`DLX_REG_AW-1:0] src2;
    logic [`DLX_REG_AW-1:0] rd;
    logic [`DLX_XLEN-1:0]   imm_ext;
    logic [`DLX_XLEN-1:0]   rs1_data;
    logic [`DLX_XLEN-1:0]   rs2_data;
    logic                   load_use;
    logic                   issue;

    //////////////////////////////////////////////////
    // field decode and control
    //////////////////////////////////////////////////

    // unused sources stay at r0 so they never match a load
    always_comb begin
        ctrl    = '0;
        alu_op  = alu_pass_b;
        src1    = instr.i.rs1;
        src2    = '0;
        rd      = '0;
        // sign-extended imm16 unless the opcode says otherwise
        imm_ext = {{(`DLX_XLEN-`DLX_IMMW){instr.i.imm[`DLX_IMMW-1]}}, instr.i.imm};
        case (instr.r.opcode)
            `DLX_OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                src2           = instr.r.rs2;
                rd             = instr.r.rd;
                case (instr.r.func)
                    `DLX_FN_ADD: alu_op = alu_add;
                    `DLX_FN_SUB: alu_op = alu_sub;
                    `DLX_FN_AND: alu_op = alu_and;
                    `DLX_FN_OR:  alu_op = alu_or;
                    `DLX_FN_XOR: alu_op = alu_xor;
                    `DLX_FN_SLT: alu_op = alu_slt;
                    // unknown func behaves as nop
                    default:     ctrl.reg_write = 1'b0;
                endcase
            end
            `DLX_OP_ADDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                alu_op         = alu_add;
                rd             = instr.i.rd;
            end
            `DLX_OP_ANDI, `DLX_OP_ORI: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                alu_op         = (instr.i.opcode == `DLX_OP_ANDI) ? alu_and : alu_or;
                rd             = instr.i.rd;
                // logical immediates are zero-extended
                imm_ext        = {{(`DLX_XLEN-`DLX_IMMW){1'b0}}, instr.i.imm};
            end
            `DLX_OP_LW: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.use_imm   = 1'b1;
                alu_op         = alu_add;
                rd             = instr.i.rd;
            end
            `DLX_OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                alu_op         = alu_add;
                // rd field names the store data register
                src2           = instr.i.rd;
            end
            `DLX_OP_BEQZ, `DLX_OP_BNEZ: begin
                ctrl.branch      = 1'b1;
                ctrl.branch_zero = (instr.i.opcode == `DLX_OP_BEQZ);
            end
            `DLX_OP_J: begin
                ctrl.jump = 1'b1;
                src1      = '0;
                // 26-bit offset spans rs1, rd and imm
                imm_ext   = {{(`DLX_XLEN-26){instr.i.rs1[`DLX_REG_AW-1]}},
                             instr.i.rs1, instr.i.rd, instr.i.imm};
            end
            default: begin
                src1 = '0;
            end
        endcase
    end

    dlx_regfile u_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1      (src1),
        .rs2      (src2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    //////////////////////////////////////////////////
    // load-use hazard and ID/EX
    //////////////////////////////////////////////////

    // load in ID/EX feeding this instruction, wait one cycle
    assign load_use = instr_valid && id_ex.valid && id_ex.ctrl.mem_read
                   && (id_ex.rd != '0) && (id_ex.rd == src1 || id_ex.rd == src2);
    // a redirect kills this instruction anyway
    assign stall = load_use && !flush;
    assign issue = instr_valid && !stall && !flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else begin
            // bubble on stall or flush
            id_ex.valid    <= issue;
            id_ex.ctrl     <= issue ? ctrl : '0;
            id_ex.alu_op   <= alu_op;
            id_ex.pc_plus4 <= pc_plus4;
            id_ex.rs1      <= src1;
            id_ex.rs2      <= src2;
            id_ex.rs1_data <= rs1_data;
            id_ex.rs2_data <= rs2_data;
            id_ex.rd       <= rd;
            id_ex.imm      <= imm_ext;
        end
    end

    a_no_load_and_store : assert property (
        @(posedge clk) disable iff (!arst_n)
        id_ex.valid |-> !(id_ex.ctrl.mem_read && id_ex.ctrl.mem_write)
    );

endmodule

//--- verilog/dlx_execute.sv
`include "dlx_params.svh"

module dlx_execute import dlx_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,
    input  dlx_id_ex_t    id_ex,
    input  dlx_mem_wb_t   mem_wb,
    output dlx_ex_mem_t   ex_mem,
    output dlx_redirect_t redirect
);

    logic [`DLX_XLEN-1:0] op_a;
    logic [`DLX_XLEN-1:0] fwd_b;
    logic [`DLX_XLEN-1:0] op_b;
    logic [`DLX_XLEN-1:0] alu_res;
    logic [`DLX_XLEN-1:0] target;
    logic                 taken;

    //////////////////////////////////////////////////
    // operand forwarding
    //////////////////////////////////////////////////

    // newest producer wins: EX/MEM, then MEM/WB, then regfile value
    function automatic logic [`DLX_XLEN-1:0] fwd_value(
        input logic [`DLX_REG_AW-1:0] idx,
        input logic [`DLX_XLEN-1:0]   reg_val
    );
        logic [`DLX_XLEN-1:0] val;
        val = reg_val;
        if (mem_wb.valid && mem_wb.reg_write && mem_wb.rd != '0 && mem_wb.rd == idx) begin
            val = mem_wb.result;
        end
        // a load here never matches, decode already stalled for it
        if (ex_mem.valid && ex_mem.reg_write && ex_mem.rd != '0 && ex_mem.rd == idx) begin
            val = ex_mem.alu_result;
        end
        return val;
    endfunction

    always_comb begin
        op_a  = fwd_value(id_ex.rs1, id_ex.rs1_data);
        fwd_b = fwd_value(id_ex.rs2, id_ex.rs2_data);
        op_b  = id_ex.ctrl.use_imm ? id_ex.imm : fwd_b;
    end

    //////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////
    always_comb begin
        case (id_ex.alu_op)
            alu_add:    alu_res = op_a + op_b;
            alu_sub:    alu_res = op_a - op_b;
            alu_and:    alu_res = op_a & op_b;
            alu_or:     alu_res = op_a | op_b;
            alu_xor:    alu_res = op_a ^ op_b;
            // signed compare
            alu_slt:    alu_res = `DLX_XLEN'($signed(op_a) < $signed(op_b));
            alu_pass_b: alu_res = op_b;
            default:    alu_res = op_b;
        endcase
    end

    //////////////////////////////////////////////////
    // branch resolution
    //////////////////////////////////////////////////

    // beqz wants rs1 zero, bnez wants it non-zero
    assign taken  = id_ex.valid && (id_ex.ctrl.jump
                 || (id_ex.ctrl.branch && ((op_a == '0) == id_ex.ctrl.branch_zero)));
    assign target = id_ex.pc_plus4 + id_ex.imm;

    // EX/MEM and redirect
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem   <= '0;
            redirect <= '0;
        end else begin
            // instruction behind a taken redirect is wrong-path
            ex_mem.valid      <= id_ex.valid && !redirect.take;
            ex_mem.reg_write  <= id_ex.ctrl.reg_write;
            ex_mem.mem_read   <= id_ex.ctrl.mem_read;
            ex_mem.mem_write  <= id_ex.ctrl.mem_write;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.rs2        <= id_ex.rs2;
            ex_mem.alu_result <= alu_res;
            // store data is the forwarded rs2, never the immediate
            ex_mem.store_val  <= fwd_b;
            redirect.take     <= taken && !redirect.take;
            redirect.target   <= target;
        end
    end

endmodule

//--- verilog/dlx_result.sv
`include "dlx_params.svh"

module dlx_result import dlx_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  dlx_ex_mem_t          ex_mem,
    output dlx_dmem_req_t        dmem_req,
    input  logic [`DLX_XLEN-1:0] dmem_rdata,
    output dlx_mem_wb_t          mem_wb,
    output dlx_wb_t              wb
);

    logic store_fwd;

    //////////////////////////////////////////////////
    // data memory request
    //////////////////////////////////////////////////

    // writeback value overrides store data when it targets rs2
    assign store_fwd = wb.we && wb.rd != '0 && wb.rd == ex_mem.rs2;

    always_comb begin
        dmem_req.addr  = ex_mem.alu_result;
        dmem_req.wdata = store_fwd ? wb.data : ex_mem.store_val;
        // bubbles and flushed entries never touch memory
        dmem_req.we    = ex_mem.valid && ex_mem.mem_write;
        dmem_req.re    = ex_mem.valid && ex_mem.mem_read;
    end

    //////////////////////////////////////////////////
    // MEM/WB and writeback
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.rd        <= ex_mem.rd;
            // load data arrives in the same cycle as the request
            mem_wb.result    <= ex_mem.mem_read ? dmem_rdata : ex_mem.alu_result;
        end
    end

    // register write port, also the bypass into decode
    always_comb begin
        wb.we   = mem_wb.valid && mem_wb.reg_write;
        wb.rd   = mem_wb.rd;
        wb.data = mem_wb.result;
    end

    // word accesses only
    a_store_aligned : assert property (
        @(posedge clk) disable iff (!arst_n)
        dmem_req.we |-> dmem_req.addr[1:0] == 2'b00
    );

endmodule

//--- verilog/dlx_core.sv
`include "dlx_params.svh"

module dlx_core import dlx_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    output logic [`DLX_XLEN-1:0] imem_addr,
    input  dlx_instr_u           imem_data,
    output dlx_dmem_req_t        dmem_req,
    input  logic [`DLX_XLEN-1:0] dmem_rdata
);

    logic [`DLX_XLEN-1:0] pc;
    logic [`DLX_XLEN-1:0] fetch_plus4;

    // IF/ID register
    logic [`DLX_XLEN-1:0] if_pc_plus4;
    dlx_instr_u           if_instr;
    logic                 if_valid;

    logic          stall;
    dlx_redirect_t redirect;
    dlx_id_ex_t    id_ex;
    dlx_ex_mem_t   ex_mem;
    dlx_mem_wb_t   mem_wb;
    dlx_wb_t       wb;

    //////////////////////////////////////////////////
    // fetch
    //////////////////////////////////////////////////

    // redirect bypasses the pc, target goes out this very cycle
    assign imem_addr   = redirect.take ? redirect.target : pc;
    assign fetch_plus4 = imem_addr + `DLX_XLEN'(4);

    // pc holds on load-use, decode never stalls under a redirect
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `DLX_RESET_PC;
        end else if (!stall) begin
            pc <= fetch_plus4;
        end
    end

    // wrong-path word in IF/ID is overwritten by the target fetch
    // and the one already in decode is dropped by its flush
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_valid    <= 1'b0;
            if_pc_plus4 <= '0;
            if_instr    <= '0;
        end else if (!stall) begin
            if_valid    <= 1'b1;
            if_pc_plus4 <= fetch_plus4;
            if_instr    <= imem_data;
        end
    end

    //////////////////////////////////////////////////
    // decode, execute, memory + writeback
    //////////////////////////////////////////////////
    dlx_decode u_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .pc_plus4    (if_pc_plus4),
        .instr       (if_instr),
        .instr_valid (if_valid),
        .wb          (wb),
        .flush       (redirect.take),
        .stall       (stall),
        .id_ex       (id_ex)
    );

    dlx_execute u_execute (
        .clk      (clk),
        .arst_n   (arst_n),
        .id_ex    (id_ex),
        .mem_wb   (mem_wb),
        .ex_mem   (ex_mem),
        .redirect (redirect)
    );

    dlx_result u_result (
        .clk        (clk),
        .arst_n     (arst_n),
        .ex_mem     (ex_mem),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .mem_wb     (mem_wb),
        .wb         (wb)
    );

    // stall comes from decode, redirect from execute
    a_no_stall_on_redirect : assert property (
        @(posedge clk) disable iff (!arst_n) redirect.take |-> !stall
    );

endmodule

//--- verification/tb_dlx_program.svh
`ifndef TB_DLX_PROGRAM_SVH
`define TB_DLX_PROGRAM_SVH

// program image, ISA-level register and memory shadow
logic [31:0] prog [0:255];
logic [31:0] ref_regs [0:31];
logic [31:0] ref_mem [0:255];
int unsigned prog_len;
int unsigned skip_left;
logic [31:0] end_pc;
// loads expected on the data port
int unsigned exp_loads;

typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
} store_t;

// expected stores, in program order
store_t exp_q[$];

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// place one word, returns 0 for words in a taken branch shadow
function automatic bit place(input logic [31:0] word);
    prog[prog_len] = word;
    prog_len++;
    if (skip_left > 0) begin
        skip_left--;
        return 1'b0;
    end
    return 1'b1;
endfunction

task automatic put_r(input logic [5:0] fn, input logic [4:0] rd, rs1, rs2);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    a = ref_regs[rs1];
    b = ref_regs[rs2];
    case (fn)
        `DLX_FN_ADD: r = a + b;
        `DLX_FN_SUB: r = a - b;
        `DLX_FN_AND: r = a & b;
        `DLX_FN_OR:  r = a | b;
        `DLX_FN_XOR: r = a ^ b;
        default:     r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endcase
    if (place({`DLX_OP_RTYPE, rs1, rs2, rd, 5'd0, fn}) && rd != 5'd0) begin
        ref_regs[rd] = r;
    end
endtask

// ADDI sign-extends, ANDI and ORI zero-extend
task automatic put_i(input logic [5:0] op, input logic [4:0] rd, rs1, input logic [15:0] imm);
    logic [31:0] a;
    logic [31:0] r;
    a = ref_regs[rs1];
    case (op)
        `DLX_OP_ADDI: r = a + {{16{imm[15]}}, imm};
        `DLX_OP_ANDI: r = a & {16'd0, imm};
        default:      r = a | {16'd0, imm};
    endcase
    if (place({op, rs1, rd, imm}) && rd != 5'd0) begin
        ref_regs[rd] = r;
    end
endtask

task automatic put_lw(input logic [4:0] rd, rs1, input logic [15:0] imm);
    logic [31:0] addr;
    addr = ref_regs[rs1] + {{16{imm[15]}}, imm};
    if (place({`DLX_OP_LW, rs1, rd, imm})) begin
        exp_loads++;
        if (rd != 5'd0) begin
            ref_regs[rd] = ref_mem[addr[9:2]];
        end
    end
endtask

// rd field of a store names the data register
task automatic put_sw(input logic [4:0] rs, rs1, input logic [15:0] imm);
    store_t s;
    s.addr = ref_regs[rs1] + {{16{imm[15]}}, imm};
    s.data = ref_regs[rs];
    if (place({`DLX_OP_SW, rs1, rs, imm})) begin
        exp_q.push_back(s);
        ref_mem[s.addr[9:2]] = s.data;
    end
endtask

// offset 12 lands past the next three words
task automatic put_branch(input logic [5:0] op, input logic [4:0] rs1);
    bit is_zero;
    is_zero = (ref_regs[rs1] == 32'd0);
    if (place({op, rs1, 5'd0, 16'd12}) && (is_zero == (op == `DLX_OP_BEQZ))) begin
        skip_left = 3;
    end
endtask

task automatic put_j_skip();
    if (place({`DLX_OP_J, 26'd12})) begin
        skip_left = 3;
    end
endtask

`endif

//--- verification/tb_dlx_core.sv
`include "dlx_params.svh"

module tb_dlx_core import dlx_pkg::*; ();

    logic                 clk;
    logic                 arst_n;
    logic [`DLX_XLEN-1:0] imem_addr;
    dlx_instr_u           imem_data;
    dlx_dmem_req_t        dmem_req;
    logic [`DLX_XLEN-1:0] dmem_rdata;

    logic [31:0] dmem [0:255];
    logic [31:0] seed;
    logic        head_valid;
    logic [31:0] head_addr;
    logic [31:0] head_data;
    logic [31:0] prev_addr;
    int unsigned end_hits;
    int unsigned loads_seen;
    int unsigned val_errs;
    int unsigned other_errs;

    `include "tb_dlx_program.svh"

    dlx_core u_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    //////////////////////////////////////////////////
    // clock and memory models
    //////////////////////////////////////////////////
    initial clk = 1'b0;
    always #2 clk = ~clk;

    // both memories answer in the same cycle
    assign imem_data  = prog[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_req.addr[9:2]];

    always @(posedge clk) begin
        if (dmem_req.we) begin
            dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
        end
    end

    // pop the head once a store has gone out
    always @(posedge clk) begin
        if (arst_n && dmem_req.we && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            if (exp_q.size() > 0) begin
                head_valid <= 1'b1;
                head_addr  <= exp_q[0].addr;
                head_data  <= exp_q[0].data;
            end else begin
                head_valid <= 1'b0;
            end
        end
    end

    // second arrival at the end word means the loop has closed
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            end_hits  <= 0;
            prev_addr <= '0;
        end else begin
            prev_addr <= imem_addr;
            // a stall holds the fetch address so only arrivals count
            if (imem_addr == end_pc && prev_addr != end_pc) begin
                end_hits <= end_hits + 1;
            end
        end
    end

    // one request cycle per load
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            loads_seen <= 0;
        end else if (dmem_req.re) begin
            loads_seen <= loads_seen + 1;
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////
    a_reset_fetch : assert property (
        @(posedge clk) !arst_n |-> imem_addr == `DLX_RESET_PC
    ) else begin
        val_errs++;
        $display("[FAIL] t=%0t imem_addr expected %h actual %h",
                 $time, `DLX_RESET_PC, $sampled(imem_addr));
    end

    a_reset_no_store : assert property (
        @(posedge clk) !arst_n |-> !dmem_req.we && !dmem_req.re
    ) else begin
        other_errs++;
        $display("t=%0t a data memory request was issued while reset was held", $time);
    end

    a_store_expected : assert property (
        @(posedge clk) disable iff (!arst_n) dmem_req.we |-> head_valid
    ) else begin
        other_errs++;
        $display("t=%0t a store came out that the program should not make", $time);
    end

    a_store_addr : assert property (
        @(posedge clk) disable iff (!arst_n)
        (dmem_req.we && head_valid) |-> dmem_req.addr == head_addr
    ) else begin
        val_errs++;
        $display("[FAIL] t=%0t dmem_req.addr expected %h actual %h",
                 $time, $sampled(head_addr), $sampled(dmem_req.addr));
    end

    a_store_data : assert property (
        @(posedge clk) disable iff (!arst_n)
        (dmem_req.we && head_valid) |-> dmem_req.wdata == head_data
    ) else begin
        val_errs++;
        $display("[FAIL] t=%0t dmem_req.wdata expected %h actual %h",
                 $time, $sampled(head_data), $sampled(dmem_req.wdata));
    end

    a_queue_drained : assert property (
        @(posedge clk) disable iff (!arst_n) end_hits >= 2 |-> !head_valid
    ) else begin
        other_errs++;
        $display("t=%0t end loop reached with stores still missing", $time);
    end

    a_load_count : assert property (
        @(posedge clk) disable iff (!arst_n) end_hits >= 2 |-> loads_seen == exp_loads
    ) else begin
        val_errs++;
        $display("[FAIL] t=%0t dmem_req.re count expected %0d actual %0d",
                 $time, exp_loads, $sampled(loads_seen));
    end

    //////////////////////////////////////////////////
    // program and stimulus
    //////////////////////////////////////////////////
    task automatic build_program();
        for (int i = 0; i < 256; i++) begin
            prog[i] = 32'd0;
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = 32'd0;
        end
        prog_len  = 0;
        skip_left = 0;
        exp_loads = 0;
        // load-use: add right after the load
        put_i(`DLX_OP_ADDI, 5'd3, 5'd0, 16'h0123);
        put_lw(5'd1, 5'd0, 16'd4);
        put_r(`DLX_FN_ADD, 5'd2, 5'd1, 5'd3);
        put_sw(5'd2, 5'd0, 16'd64);
        // dependent chain, each using the last result
        put_i(`DLX_OP_ADDI, 5'd4, 5'd0, 16'd7);
        put_i(`DLX_OP_ADDI, 5'd4, 5'd4, 16'hfff7);
        put_i(`DLX_OP_ORI, 5'd5, 5'd4, 16'hf0f0);
        put_i(`DLX_OP_ANDI, 5'd6, 5'd5, 16'h0ff3);
        put_r(`DLX_FN_SUB, 5'd7, 5'd4, 5'd6);
        put_r(`DLX_FN_XOR, 5'd8, 5'd7, 5'd5);
        put_r(`DLX_FN_SLT, 5'd9, 5'd7, 5'd0);
        put_r(`DLX_FN_OR, 5'd9, 5'd9, 5'd6);
        put_r(`DLX_FN_AND, 5'd10, 5'd9, 5'd8);
        put_sw(5'd10, 5'd0, 16'd68);
        put_sw(5'd8, 5'd0, 16'd72);
        // store data from two instructions back
        put_r(`DLX_FN_ADD, 5'd11, 5'd8, 5'd1);
        put_i(`DLX_OP_ADDI, 5'd12, 5'd0, 16'd1);
        put_sw(5'd11, 5'd0, 16'd76);
        put_i(`DLX_OP_ADDI, 5'd12, 5'd1, 16'hfffd);
        put_sw(5'd12, 5'd0, 16'd80);
        // taken branches with their skipped stores
        put_branch(`DLX_OP_BEQZ, 5'd0);
        put_sw(5'd4, 5'd0, 16'd200);
        put_sw(5'd5, 5'd0, 16'd204);
        put_sw(5'd6, 5'd0, 16'd208);
        put_branch(`DLX_OP_BNEZ, 5'd4);
        put_sw(5'd4, 5'd0, 16'd212);
        put_sw(5'd5, 5'd0, 16'd216);
        put_sw(5'd6, 5'd0, 16'd220);
        // untaken ones fall through
        put_branch(`DLX_OP_BEQZ, 5'd4);
        put_sw(5'd4, 5'd0, 16'd84);
        put_sw(5'd5, 5'd0, 16'd88);
        put_sw(5'd6, 5'd0, 16'd92);
        put_branch(`DLX_OP_BNEZ, 5'd0);
        put_sw(5'd7, 5'd0, 16'd96);
        put_sw(5'd9, 5'd0, 16'd100);
        put_sw(5'd3, 5'd0, 16'd104);
        put_j_skip();
        put_sw(5'd4, 5'd0, 16'd224);
        put_sw(5'd5, 5'd0, 16'd228);
        put_sw(5'd6, 5'd0, 16'd232);
        // r0 write is dropped
        put_i(`DLX_OP_ADDI, 5'd0, 5'd0, 16'd55);
        put_sw(5'd0, 5'd0, 16'd120);
        // reload a stored word and store it straight back
        put_lw(5'd13, 5'd0, 16'd64);
        put_sw(5'd13, 5'd0, 16'd124);
        end_pc = prog_len * 4;
        void'(place({`DLX_OP_J, 26'h3ff_fffc}));
    endtask

    initial begin
        arst_n     = 1'b0;
        val_errs   = 0;
        other_errs = 0;
        seed       = 32'd48;
        // data memory and its shadow start from the same lcg sequence
        for (int i = 0; i < 256; i++) begin
            seed       = lcg_next(seed);
            dmem[i]    <= seed;
            ref_mem[i] = seed;
        end
        build_program();
        head_valid <= (exp_q.size() > 0);
        head_addr  <= exp_q[0].addr;
        head_data  <= exp_q[0].data;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        wait (end_hits >= 2);
        @(posedge clk);
        @(negedge clk);
        $display("errors: %0d wrong values, %0d other, %0d stores pending",
                 val_errs, other_errs, exp_q.size());
        if (val_errs == 0 && other_errs == 0 && !head_valid) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // 20 cycles per program word on top of reset
    initial begin
        wait (prog_len > 0);
        #((5 + 20 * prog_len) * 4);
        $display("watchdog expired, the program never reached its end loop");
        $display("errors: %0d wrong values, %0d other, %0d stores pending",
                 val_errs, other_errs + 1, exp_q.size());
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- sources.f
+incdir+verilog
+incdir+verification
verilog/dlx_pkg.sv
verilog/dlx_regfile.sv
verilog/dlx_decode.sv
verilog/dlx_execute.sv
verilog/dlx_result.sv
verilog/dlx_core.sv
verification/tb_dlx_core.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the DLX core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_dlx_core -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vtb_dlx_core > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "no result line, see sim.log"; exit 1; }
echo "simulation passed"
